/* Bender.yml */
package:
  name: kmac_prefix

export_include_dirs:
  - .

sources:
  - files:
      - kmac_pkg.sv
      - kmac_key_if.sv
      - kmac_ctrl.sv
      - kmac_key_index.sv
      - kmac_msg_datapath.sv
      - kmac_prefix_top.sv
  - target: test
    files:
      - kmac_assertions.sv
      - kmac_tb.sv

/* kmac_assertions.sv */
////////////////////
// KMAC prefix assertions
// FSM and handshake properties on the top level
////////////////////

`timescale 1ns/10ps
`default_nettype none

module kmac_assertions (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       fifo_valid_i,
  input logic       fifo_ready_i,
  input logic       key_valid_i,
  input logic       proc_out_i,
  input logic [5:0] st_i,
  input logic       latch_i
);

  // FIFO held off while key words go out
  no_fifo_in_key: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(key_valid_i && fifo_valid_i && fifo_ready_i))
    else $error("FIFO transfer while key block is pending");

  // Process only leaves in Msg or in bypass
  no_proc_key_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (st_i inside {kmac_pkg::Key, kmac_pkg::Flush}) |-> !proc_out_i)
    else $error("process_o high in Key or Flush");

  legal_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    st_i inside {kmac_pkg::Idle, kmac_pkg::Key, kmac_pkg::Msg,
                 kmac_pkg::Flush, kmac_pkg::TerminalError})
    else $error("State register holds an illegal code");

  // Latched request is replayed right away in Msg
  latch_clears: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (st_i == kmac_pkg::Msg && latch_i) |=> !latch_i)
    else $error("Process latch not cleared after Msg");

endmodule

bind kmac_prefix_top kmac_assertions u_assertions (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .fifo_valid_i (fifo_valid_i),
  .fifo_ready_i (fifo_ready_o),
  .key_valid_i  (key_valid),
  .proc_out_i   (process_o),
  .st_i         (u_ctrl.st_q),
  .latch_i      (u_ctrl.process_latched_q)
);

`default_nettype wire

/* kmac_consts.svh */
////////////////////
// KMAC key-prefix constants
// Widths and rate block sizes shared by the prefix stage
////////////////////

`ifndef KMAC_CONSTS_SVH
`define KMAC_CONSTS_SVH

// Message word towards the absorb engine
`define KMAC_MSG_W 64

// One strobe bit per message byte
`define KMAC_STRB_W 8

// Largest key the stage accepts, in bits
`define KMAC_MAX_KEY_W 512

// Key word index, wide enough for the largest rate count
`define KMAC_IDX_W 5

// Rate block size in 64-bit words
// L128 rate is 168 bytes, L256 rate is 136 bytes
`define KMAC_RATE_L128 21
`define KMAC_RATE_L256 17

`endif

/* kmac_ctrl.sv */
////////////////////
// KMAC prefix controller
// Sparse FSM that pushes the key block, gates process
// and latches an early process request
////////////////////

`timescale 1ns/10ps
`default_nettype none

module kmac_ctrl (
  input  logic        clk_i,
  input  logic        rst_ni,

  // Configuration and commands
  input  logic        kmac_en_i,
  input  logic        start_i,
  input  logic        process_i,
  input  logic        done_i,

  // Life cycle escalation level
  input  logic        escalate_i,

  // Key index counter
  kmac_key_if.ctrl_mp key_if,

  // To datapath
  output logic        key_phase_o,
  output logic        key_valid_o,

  // To absorb engine
  output logic        process_o,
  output logic        sparse_fsm_error_o,

  // Absorb engine ready, for the index increment
  input  logic        msg_ready_i
);

  kmac_pkg::kmac_st_e st_q, st_d;

  // Process request seen in Key, replayed in Msg
  logic process_latched_q;
  logic kmac_process;

  ////////////////////
  // State machine
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q <= kmac_pkg::Idle;
    end else begin
      st_q <= st_d;
    end
  end

  always_comb begin
    st_d               = st_q;
    key_phase_o        = 1'b0;
    key_valid_o        = 1'b0;
    key_if.clr         = 1'b0;
    kmac_process       = 1'b0;
    sparse_fsm_error_o = 1'b0;

    case (st_q)
      kmac_pkg::Idle: begin
        if (kmac_en_i && start_i) begin
          st_d = kmac_pkg::Key;
        end
      end

      // Full rate block of key words, whatever process does
      kmac_pkg::Key: begin
        key_phase_o = 1'b1;
        if (key_if.sent_block) begin
          // Block complete, rewind index for the next start
          key_if.clr = 1'b1;
          st_d       = kmac_pkg::Msg;
        end else begin
          key_valid_o = 1'b1;
        end
      end

      // Message passes through, wait for process
      kmac_pkg::Msg: begin
        if (process_i || process_latched_q) begin
          kmac_process = 1'b1;
          st_d         = kmac_pkg::Flush;
        end
      end

      kmac_pkg::Flush: begin
        if (done_i) begin
          st_d = kmac_pkg::Idle;
        end
      end

      kmac_pkg::TerminalError: begin
        sparse_fsm_error_o = 1'b1;
      end

      // Any code outside the enum is a fault
      default: begin
        st_d               = kmac_pkg::TerminalError;
        sparse_fsm_error_o = 1'b1;
      end
    endcase

    // Escalation wins over every transition
    if (escalate_i) begin
      st_d = kmac_pkg::TerminalError;
    end
  end

  // One index step per accepted key word
  assign key_if.inc = key_valid_o & msg_ready_i;

  ////////////////////
  // Process gating
  ////////////////////

  // Bypass when KMAC is off
  assign process_o = kmac_en_i ? kmac_process : process_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      process_latched_q <= 1'b0;
    end else if (process_i && !process_o) begin
      process_latched_q <= 1'b1;
    end else if (process_o || done_i) begin
      process_latched_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* kmac_key_if.sv */
////////////////////
// Key index interface
// Counter controls and status between FSM and counter
////////////////////

`timescale 1ns/10ps
`default_nettype none

interface kmac_key_if;

  // Counter controls from the FSM
  logic clr;
  logic inc;

  // Status back from the counter
  logic sent_block;
  kmac_pkg::key_idx_t index;

  // FSM side
  modport ctrl_mp (
    output clr,
    output inc,
    input  sent_block
  );

  // Hardened counter side
  modport cnt_mp (
    input  clr,
    input  inc,
    output sent_block,
    output index
  );

  // Datapath only needs the word select
  modport dp_mp (
    input index
  );

endinterface

`default_nettype wire

/* kmac_key_index.sv */
////////////////////
// Hardened key word counter
// Redundant up counter with block limit and mismatch error
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "kmac_consts.svh"

module kmac_key_index (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  kmac_pkg::strength_e strength_i,
  kmac_key_if.cnt_mp         key_if,
  output logic               key_index_error_o
);

  // Primary count and its complement copy
  kmac_pkg::key_idx_t cnt_q;
  kmac_pkg::key_idx_t cnt_n_q;
  kmac_pkg::key_idx_t block_limit;
  logic               mismatch;
  logic               err_q;

  // Complement copy counts down on its own adder
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q   <= '0;
      cnt_n_q <= '1;
    end else if (key_if.clr) begin
      cnt_q   <= '0;
      cnt_n_q <= '1;
    end else if (key_if.inc) begin
      cnt_q   <= cnt_q + 1'b1;
      cnt_n_q <= cnt_n_q - 1'b1;
    end
  end

  // Copies must stay bitwise inverse
  assign mismatch = (cnt_q != ~cnt_n_q);

  // Sticky until reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else if (mismatch) begin
      err_q <= 1'b1;
    end
  end

  assign key_index_error_o = err_q;

  // Words per rate block
  assign block_limit = (strength_i == kmac_pkg::L128) ?
                       kmac_pkg::key_idx_t'(`KMAC_RATE_L128) :
                       kmac_pkg::key_idx_t'(`KMAC_RATE_L256);

  assign key_if.index      = cnt_q;
  assign key_if.sent_block = (cnt_q == block_limit);

endmodule

`default_nettype wire

/* kmac_msg_datapath.sv */
////////////////////
// KMAC prefix datapath
// Builds bytepad(encode_string(K)) and muxes key words
// or FIFO data onto the absorb port
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "kmac_consts.svh"

module kmac_msg_datapath (
  input  kmac_pkg::strength_e strength_i,
  input  kmac_pkg::key_len_e  key_len_i,
  input  kmac_pkg::key_data_t key_data_i,

  // Word select from the counter
  kmac_key_if.dp_mp           key_if,

  // From controller
  input  logic                key_phase_i,
  input  logic                key_valid_i,

  // Message FIFO side
  input  logic                fifo_valid_i,
  input  kmac_pkg::msg_word_t fifo_data_i,
  input  kmac_pkg::msg_strb_t fifo_strb_i,
  output logic                fifo_ready_o,

  // Absorb engine side
  output logic                msg_valid_o,
  output kmac_pkg::msg_word_t msg_data_o,
  output kmac_pkg::msg_strb_t msg_strb_o,
  input  logic                msg_ready_i
);

  // Encoded block rounded up to whole words
  localparam int BlockW     = $bits(kmac_pkg::enc_block_t);
  localparam int BlockWords = (BlockW + `KMAC_MSG_W - 1) / `KMAC_MSG_W;
  localparam int PadW       = BlockWords * `KMAC_MSG_W;

  logic [15:0]          encode_bytepad;
  logic [23:0]          encode_keylen;
  logic [BlockW-41:0]   padded_key;
  kmac_pkg::enc_block_t enc_block;
  logic [PadW-1:0]      enc_words;
  kmac_pkg::msg_word_t  key_word;

  ////////////////////
  // Block encoding
  ////////////////////

  // left_encode(rate), byte 0 in the low bits
  assign encode_bytepad = (strength_i == kmac_pkg::L128) ? 16'hA801 : 16'h8801;

  // left_encode(key length) with the length field swapped to little endian
  // Short keys use one length byte, so only 16 bits count
  always_comb begin
    case (key_len_i)
      kmac_pkg::Key128: encode_keylen = 24'h00_80_01;
      kmac_pkg::Key192: encode_keylen = 24'h00_C0_01;
      kmac_pkg::Key256: encode_keylen = 24'h00_01_02;
      kmac_pkg::Key384: encode_keylen = 24'h80_01_02;
      kmac_pkg::Key512: encode_keylen = 24'h00_02_02;
      default:          encode_keylen = 24'h00_00_00;
    endcase
  end

  // Key bytes trimmed to their length, zeros above
  always_comb begin
    case (key_len_i)
      kmac_pkg::Key128: padded_key = {384'h0, key_data_i[127:0]};
      kmac_pkg::Key192: padded_key = {320'h0, key_data_i[191:0]};
      kmac_pkg::Key256: padded_key = {256'h0, key_data_i[255:0]};
      kmac_pkg::Key384: padded_key = {128'h0, key_data_i[383:0]};
      default:          padded_key = key_data_i;
    endcase
  end

  // Key starts right after the last used length byte
  always_comb begin
    if (key_len_i inside {kmac_pkg::Key128, kmac_pkg::Key192}) begin
      enc_block = {8'h00, padded_key, encode_keylen[15:0], encode_bytepad};
    end else begin
      enc_block = {padded_key, encode_keylen, encode_bytepad};
    end
  end

  ////////////////////
  // Word slicing
  ////////////////////

  assign enc_words = {{(PadW - BlockW){1'b0}}, enc_block};

  // Rest of the rate block is zero fill
  always_comb begin
    if (int'(key_if.index) < BlockWords) begin
      key_word = enc_words[int'(key_if.index) * `KMAC_MSG_W +: `KMAC_MSG_W];
    end else begin
      key_word = '0;
    end
  end

  ////////////////////
  // Output mux
  ////////////////////

  // FIFO held off while the key block goes out
  assign msg_valid_o  = key_phase_i ? key_valid_i : fifo_valid_i;
  assign msg_data_o   = key_phase_i ? key_word    : fifo_data_i;
  assign msg_strb_o   = key_phase_i ? '1          : fifo_strb_i;
  assign fifo_ready_o = key_phase_i ? 1'b0        : msg_ready_i;

endmodule

`default_nettype wire

/* kmac_pkg.sv */
////////////////////
// KMAC key-prefix package
// Vector types and enums for the prefix stage
////////////////////

`default_nettype none

`include "kmac_consts.svh"

package kmac_pkg;

  // One word on the message path
  typedef logic [`KMAC_MSG_W-1:0] msg_word_t;
  typedef logic [`KMAC_STRB_W-1:0] msg_strb_t;

  // Key from CSR, least significant byte first
  typedef logic [`KMAC_MAX_KEY_W-1:0] key_data_t;

  // Word index inside one rate block
  typedef logic [`KMAC_IDX_W-1:0] key_idx_t;

  // bytepad prefix (16) + key length encoding (24) + key
  typedef logic [`KMAC_MAX_KEY_W+40-1:0] enc_block_t;

  // Only the two SHAKE strengths KMAC uses
  typedef enum logic {
    L128 = 1'b0,
    L256 = 1'b1
  } strength_e;

  typedef enum logic [2:0] {
    Key128 = 3'd0,
    Key192 = 3'd1,
    Key256 = 3'd2,
    Key384 = 3'd3,
    Key512 = 3'd4
  } key_len_e;

  // Sparse codes, minimum Hamming distance 3
  typedef enum logic [5:0] {
    Idle          = 6'b011000,
    Key           = 6'b010111,
    Msg           = 6'b001110,
    Flush         = 6'b101011,
    TerminalError = 6'b100000
  } kmac_st_e;

endpackage

`default_nettype wire

/* kmac_prefix_top.sv */
////////////////////
// KMAC key-prefix stage
// Sits between message FIFO and absorb engine
////////////////////

`timescale 1ns/10ps
`default_nettype none

module kmac_prefix_top (
  input  logic                clk_i,
  input  logic                rst_ni,

  // Configuration
  input  logic                kmac_en_i,
  input  kmac_pkg::strength_e strength_i,
  input  kmac_pkg::key_len_e  key_len_i,
  input  kmac_pkg::key_data_t key_data_i,

  // Commands
  input  logic                start_i,
  input  logic                process_i,
  input  logic                done_i,
  input  logic                escalate_i,

  // Message FIFO
  input  logic                fifo_valid_i,
  input  kmac_pkg::msg_word_t fifo_data_i,
  input  kmac_pkg::msg_strb_t fifo_strb_i,
  output logic                fifo_ready_o,

  // Absorb engine
  output logic                msg_valid_o,
  output kmac_pkg::msg_word_t msg_data_o,
  output kmac_pkg::msg_strb_t msg_strb_o,
  input  logic                msg_ready_i,
  output logic                process_o,

  // Error status
  output logic                sparse_fsm_error_o,
  output logic                key_index_error_o
);

  logic key_phase;
  logic key_valid;

  kmac_key_if key_if_i ();

  kmac_ctrl u_ctrl (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .kmac_en_i          (kmac_en_i),
    .start_i            (start_i),
    .process_i          (process_i),
    .done_i             (done_i),
    .escalate_i         (escalate_i),
    .key_if             (key_if_i.ctrl_mp),
    .key_phase_o        (key_phase),
    .key_valid_o        (key_valid),
    .process_o          (process_o),
    .sparse_fsm_error_o (sparse_fsm_error_o),
    .msg_ready_i        (msg_ready_i)
  );

  kmac_key_index u_key_index (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .strength_i        (strength_i),
    .key_if            (key_if_i.cnt_mp),
    .key_index_error_o (key_index_error_o)
  );

  kmac_msg_datapath u_datapath (
    .strength_i   (strength_i),
    .key_len_i    (key_len_i),
    .key_data_i   (key_data_i),
    .key_if       (key_if_i.dp_mp),
    .key_phase_i  (key_phase),
    .key_valid_i  (key_valid),
    .fifo_valid_i (fifo_valid_i),
    .fifo_data_i  (fifo_data_i),
    .fifo_strb_i  (fifo_strb_i),
    .fifo_ready_o (fifo_ready_o),
    .msg_valid_o  (msg_valid_o),
    .msg_data_o   (msg_data_o),
    .msg_strb_o   (msg_strb_o),
    .msg_ready_i  (msg_ready_i)
  );

endmodule

`default_nettype wire

/* kmac_tb.sv */
////////////////////
// KMAC key-prefix testbench
// Table-driven checks of key block, pass-through and process gating
////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "kmac_consts.svh"

module kmac_tb;

  // One test row: config, key, message length, process timing, stalls
  typedef struct packed {
    logic                en;
    kmac_pkg::strength_e str;
    kmac_pkg::key_len_e  klen;
    kmac_pkg::key_data_t key;
    logic [7:0]          words;
    logic                early;
    logic [7:0]          stalls;
  } row_t;

  localparam int NumRows = 11;

  logic                clk_i;
  logic                rst_ni;
  logic                kmac_en_i;
  kmac_pkg::strength_e strength_i;
  kmac_pkg::key_len_e  key_len_i;
  kmac_pkg::key_data_t key_data_i;
  logic                start_i;
  logic                process_i;
  logic                done_i;
  logic                escalate_i;
  logic                fifo_valid_i;
  kmac_pkg::msg_word_t fifo_data_i;
  kmac_pkg::msg_strb_t fifo_strb_i;
  logic                fifo_ready_o;
  logic                msg_valid_o;
  kmac_pkg::msg_word_t msg_data_o;
  kmac_pkg::msg_strb_t msg_strb_o;
  logic                msg_ready_i;
  logic                process_o;
  logic                sparse_fsm_error_o;
  logic                key_index_error_o;

  row_t   rows [NumRows];
  integer seed = 87027;
  int     errors = 0;
  int     checks = 0;
  int     cycles = 0;
  int     limit = 0;
  int     proc_pulses = 0;

  kmac_prefix_top dut_i (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .kmac_en_i          (kmac_en_i),
    .strength_i         (strength_i),
    .key_len_i          (key_len_i),
    .key_data_i         (key_data_i),
    .start_i            (start_i),
    .process_i          (process_i),
    .done_i             (done_i),
    .escalate_i         (escalate_i),
    .fifo_valid_i       (fifo_valid_i),
    .fifo_data_i        (fifo_data_i),
    .fifo_strb_i        (fifo_strb_i),
    .fifo_ready_o       (fifo_ready_o),
    .msg_valid_o        (msg_valid_o),
    .msg_data_o         (msg_data_o),
    .msg_strb_o         (msg_strb_o),
    .msg_ready_i        (msg_ready_i),
    .process_o          (process_o),
    .sparse_fsm_error_o (sparse_fsm_error_o),
    .key_index_error_o  (key_index_error_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Run limit from the summed test lengths
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_word(input string name, input kmac_pkg::msg_word_t got,
                            input kmac_pkg::msg_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_strb(input string name, input kmac_pkg::msg_strb_t got,
                            input kmac_pkg::msg_strb_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  function automatic int rate_words(input kmac_pkg::strength_e s);
    return (s == kmac_pkg::L128) ? `KMAC_RATE_L128 : `KMAC_RATE_L256;
  endfunction

  // Distinct byte per position so slicing errors show
  function automatic kmac_pkg::key_data_t make_key(input logic [7:0] tag);
    kmac_pkg::key_data_t k;
    int i;
    for (i = 0; i < 64; i++) begin
      k[8*i +: 8] = tag ^ 8'(i * 29 + 3);
    end
    return k;
  endfunction

  // bytepad(encode_string(K), rate), word idx, byte 0 lowest
  function automatic kmac_pkg::msg_word_t expected_word(input row_t r, input int idx);
    logic [7:0] blk [0:167];
    int key_bits;
    int n;
    int i;
    kmac_pkg::msg_word_t w;
    for (i = 0; i < 168; i++) begin
      blk[i] = 8'h00;
    end
    case (r.klen)
      kmac_pkg::Key128: key_bits = 128;
      kmac_pkg::Key192: key_bits = 192;
      kmac_pkg::Key256: key_bits = 256;
      kmac_pkg::Key384: key_bits = 384;
      default:          key_bits = 512;
    endcase
    // left_encode(rate in bytes)
    blk[0] = 8'h01;
    blk[1] = 8'(rate_words(r.str) * 8);
    // left_encode(key bits), big endian length field
    if (key_bits < 256) begin
      blk[2] = 8'h01;
      blk[3] = 8'(key_bits);
      n = 4;
    end else begin
      blk[2] = 8'h02;
      blk[3] = 8'(key_bits >> 8);
      blk[4] = 8'(key_bits);
      n = 5;
    end
    for (i = 0; i < key_bits / 8; i++) begin
      blk[n + i] = r.key[8*i +: 8];
    end
    for (i = 0; i < 8; i++) begin
      w[8*i +: 8] = blk[8*idx + i];
    end
    return w;
  endfunction

  ////////////////////
  // Stimulus tasks
  ////////////////////

  // Sample once outputs settle after the falling edge
  task automatic watch_cycle();
    #1;
    if (process_o) begin
      proc_pulses++;
    end
    check_bit("key_index_error_o", key_index_error_o, 1'b0);
  endtask

  task automatic check_forwarding();
    check_bit("msg_valid_o", msg_valid_o, fifo_valid_i);
    check_word("msg_data_o", msg_data_o, fifo_data_i);
    check_strb("msg_strb_o", msg_strb_o, fifo_strb_i);
    check_bit("fifo_ready_o", fifo_ready_o, msg_ready_i);
  endtask

  task automatic drive_fifo_word();
    kmac_pkg::msg_word_t data;
    data = {$random(seed), $random(seed)};
    fifo_valid_i = 1'b1;
    fifo_data_i  = data;
    fifo_strb_i  = data[15:8];
  endtask

  // KMAC off, start ignored and everything passes straight through
  task automatic run_bypass(input row_t r);
    int m;
    for (m = 0; m < r.words + r.stalls; m++) begin
      @(negedge clk_i);
      kmac_en_i = 1'b0;
      start_i   = (m == 0);
      drive_fifo_word();
      fifo_valid_i = fifo_data_i[0];
      msg_ready_i  = fifo_data_i[1];
      process_i    = fifo_data_i[2];
      watch_cycle();
      check_forwarding();
      check_bit("process_o", process_o, process_i);
    end
    @(negedge clk_i);
    start_i   = 1'b0;
    process_i = 1'b0;
  endtask

  task automatic run_keyed(input row_t r);
    int sent;
    int stalls_left;
    int m;
    logic proc_given;
    sent = 0;
    stalls_left = r.stalls;
    proc_given = 1'b0;
    proc_pulses = 0;
    @(negedge clk_i);
    kmac_en_i    = 1'b1;
    strength_i   = r.str;
    key_len_i    = r.klen;
    key_data_i   = r.key;
    fifo_valid_i = 1'b0;
    start_i      = 1'b1;
    watch_cycle();
    // Key block, FIFO has a word waiting that must stay blocked
    while (sent < rate_words(r.str)) begin
      @(negedge clk_i);
      start_i      = 1'b0;
      fifo_valid_i = 1'b1;
      msg_ready_i  = !(stalls_left > 0 && ($random(seed) & 1));
      if (!msg_ready_i) begin
        stalls_left--;
      end
      process_i = r.early && !proc_given && sent == 2;
      if (process_i) begin
        proc_given = 1'b1;
      end
      watch_cycle();
      check_bit("msg_valid_o", msg_valid_o, 1'b1);
      check_bit("fifo_ready_o", fifo_ready_o, 1'b0);
      if (msg_ready_i) begin
        check_word("msg_data_o", msg_data_o, expected_word(r, sent));
        check_strb("msg_strb_o", msg_strb_o, 8'hFF);
        sent++;
      end
    end
    // Block complete, no extra key word
    @(negedge clk_i);
    process_i   = 1'b0;
    msg_ready_i = 1'b1;
    watch_cycle();
    check_bit("msg_valid_o", msg_valid_o, 1'b0);
    check_bit("process_o", proc_pulses != 0, 1'b0);
    for (m = 0; m < r.words; m++) begin
      @(negedge clk_i);
      drive_fifo_word();
      watch_cycle();
      check_forwarding();
    end
    @(negedge clk_i);
    fifo_valid_i = 1'b0;
    process_i    = !r.early;
    watch_cycle();
    @(negedge clk_i);
    process_i = 1'b0;
    done_i    = 1'b1;
    watch_cycle();
    @(negedge clk_i);
    done_i = 1'b0;
    watch_cycle();
    check_bit("process_o single pulse", proc_pulses == 1, 1'b1);
  endtask

  // Escalation is terminal, later starts see plain forwarding
  task automatic run_escalation();
    int m;
    @(negedge clk_i);
    escalate_i = 1'b1;
    watch_cycle();
    @(negedge clk_i);
    escalate_i = 1'b0;
    watch_cycle();
    check_bit("sparse_fsm_error_o", sparse_fsm_error_o, 1'b1);
    for (m = 0; m < 9; m++) begin
      @(negedge clk_i);
      kmac_en_i = 1'b1;
      start_i   = (m % 3 == 0);
      drive_fifo_word();
      msg_ready_i = fifo_data_i[1];
      watch_cycle();
      check_forwarding();
      check_bit("sparse_fsm_error_o", sparse_fsm_error_o, 1'b1);
    end
    @(negedge clk_i);
    start_i = 1'b0;
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    int r;
    int errs_before;
    rst_ni       = 1'b0;
    kmac_en_i    = 1'b0;
    strength_i   = kmac_pkg::L128;
    key_len_i    = kmac_pkg::Key128;
    key_data_i   = '0;
    start_i      = 1'b0;
    process_i    = 1'b0;
    done_i       = 1'b0;
    escalate_i   = 1'b0;
    fifo_valid_i = 1'b0;
    fifo_data_i  = '0;
    fifo_strb_i  = '0;
    msg_ready_i  = 1'b1;

    // en, strength, key length, key, words, early process, stalls
    rows[0]  = '{1'b0, kmac_pkg::L128, kmac_pkg::Key128, make_key(8'h10), 8'd6, 1'b0, 8'd3};
    rows[1]  = '{1'b1, kmac_pkg::L128, kmac_pkg::Key128, make_key(8'h21), 8'd3, 1'b1, 8'd4};
    rows[2]  = '{1'b1, kmac_pkg::L256, kmac_pkg::Key128, make_key(8'h32), 8'd2, 1'b0, 8'd2};
    rows[3]  = '{1'b1, kmac_pkg::L128, kmac_pkg::Key192, make_key(8'h43), 8'd2, 1'b0, 8'd0};
    rows[4]  = '{1'b1, kmac_pkg::L256, kmac_pkg::Key192, make_key(8'h54), 8'd3, 1'b1, 8'd5};
    rows[5]  = '{1'b1, kmac_pkg::L128, kmac_pkg::Key256, make_key(8'h65), 8'd4, 1'b1, 8'd6};
    rows[6]  = '{1'b1, kmac_pkg::L256, kmac_pkg::Key256, make_key(8'h76), 8'd2, 1'b0, 8'd3};
    rows[7]  = '{1'b1, kmac_pkg::L128, kmac_pkg::Key384, make_key(8'h87), 8'd3, 1'b0, 8'd1};
    rows[8]  = '{1'b1, kmac_pkg::L256, kmac_pkg::Key384, make_key(8'h98), 8'd2, 1'b1, 8'd4};
    rows[9]  = '{1'b1, kmac_pkg::L128, kmac_pkg::Key512, make_key(8'hA9), 8'd2, 1'b1, 8'd3};
    rows[10] = '{1'b1, kmac_pkg::L256, kmac_pkg::Key512, make_key(8'hBA), 8'd3, 1'b0, 8'd2};

    limit = 16 + 30;
    for (r = 0; r < NumRows; r++) begin
      limit += rate_words(rows[r].str) + rows[r].words + rows[r].stalls + 20;
    end

    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    for (r = 0; r < NumRows; r++) begin
      errs_before = errors;
      if (rows[r].en) begin
        run_keyed(rows[r]);
      end else begin
        run_bypass(rows[r]);
      end
      // No FSM error before escalation
      check_bit("sparse_fsm_error_o", sparse_fsm_error_o, 1'b0);
      $display("Row %0d: kmac_en=%0d strength=%0d key_len=%0d words=%0d, %0d errors",
               r, rows[r].en, rows[r].str, rows[r].klen, rows[r].words,
               errors - errs_before);
    end

    errs_before = errors;
    run_escalation();
    $display("Escalation: %0d errors", errors - errs_before);

    $display("Checks run: %0d, checks failed: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
kmac_pkg.sv
kmac_key_if.sv
kmac_ctrl.sv
kmac_key_index.sv
kmac_msg_datapath.sv
kmac_prefix_top.sv
kmac_assertions.sv
kmac_tb.sv
